// File: tb.f
verilog/xbar_cfg_pkg.sv
verilog/xbar_msg_pkg.sv
verilog/xbar_ctrl_decode.sv
verilog/xbar_route.sv
verilog/xbar_send_buf.sv
verilog/xbar_top.sv
test/tb_xbar_check.sv
test/tb_xbar.sv

// File: Makefile
# Verilator build and run for the crossbar testbench

VERILATOR ?= verilator
TOP       ?= tb_xbar
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv) $(wildcard test/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_xbar.sv
module tb_xbar
  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ctrl_limit    = 20;
  localparam int traffic_limit = 2000;
  localparam int drain_limit   = 200;

  logic                       clk = 1'b0;
  logic                       rst;
  logic [n_inputs*msg_w-1:0]  recv_msg;
  in_mask_t                   recv_val;
  in_mask_t                   recv_rdy;
  logic [n_outputs*msg_w-1:0] send_msg;
  out_mask_t                  send_val;
  out_mask_t                  send_rdy;
  ctrl_word_t                 control;
  logic                       control_val;
  logic                       control_rdy;

  int          seed = 32'h53bd;
  int          test_id;
  int unsigned pending;
  logic        check_failed;

  always #50 clk = ~clk;

  xbar_top u_dut (
    .recv_msg    (recv_msg),
    .recv_val    (recv_val),
    .recv_rdy    (recv_rdy),
    .send_msg    (send_msg),
    .send_val    (send_val),
    .send_rdy    (send_rdy),
    .rst         (rst),
    .clk         (clk),
    .control     (control),
    .control_val (control_val),
    .control_rdy (control_rdy)
  );

  tb_xbar_check u_check (
    .clk         (clk),
    .rst         (rst),
    .recv_msg    (recv_msg),
    .recv_val    (recv_val),
    .recv_rdy    (recv_rdy),
    .send_msg    (send_msg),
    .send_val    (send_val),
    .send_rdy    (send_rdy),
    .control     (control),
    .control_val (control_val),
    .control_rdy (control_rdy),
    .test_id     (test_id),
    .pending     (pending),
    .failed      (check_failed)
  );

  always @(posedge check_failed) begin
    $display("Regression failed");
    $fatal(1, "checker found a mismatch");
  end

  task automatic fail_now(input string why);
    $display("Regression failed");
    $fatal(1, "%s", why);
  endtask

  // source input per output where a negative value disables it
  function automatic route_vec_t routing(input int s0, input int s1, input int s2,
                                         input int s3);
    int         src [n_outputs];
    route_vec_t r;
    src = '{s0, s1, s2, s3};
    for (int o = 0; o < n_outputs; o++) begin
      r[o].en  = (src[o] >= 0);
      r[o].sel = port_sel_t'(src[o]);
    end
    return r;
  endfunction

  // entered and left 10 ns after a rising edge
  task automatic send_control(input route_vec_t r);
    int   cycles;
    logic done;
    cycles      = 0;
    done        = 1'b0;
    control     = ctrl_word_t'(r);
    control_val = 1'b1;
    while (!done) begin
      if (cycles == ctrl_limit) fail_now("control word was never accepted");
      else begin
        #80;
        done = control_rdy;
        @(posedge clk);
        #10;
        cycles++;
      end
    end
    control_val = 1'b0;
  endtask

  // feed inputs deliver n_each messages and parked inputs stay valid uncounted
  // jitter marks the outputs whose send_rdy is random
  task automatic run_traffic(input int n_each, input in_mask_t feed, input in_mask_t parked,
                             input out_mask_t jitter);
    int          left [n_inputs];
    int          cycles;
    logic        busy;
    in_mask_t    xfer;
    logic [31:0] rnd;
    for (int s = 0; s < n_inputs; s++) left[s] = feed[s] ? n_each : 0;
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      if (cycles == traffic_limit) fail_now("traffic did not finish within the cycle limit");
      else begin
        for (int s = 0; s < n_inputs; s++) begin
          if (!recv_val[s] && (left[s] > 0 || parked[s])) begin
            recv_msg[s*msg_w +: msg_w] = $random(seed);
            recv_val[s] = 1'b1;
          end
        end
        for (int o = 0; o < n_outputs; o++) begin
          rnd = $random(seed);
          send_rdy[o] = jitter[o] ? rnd[0] : 1'b1;
        end
        #80;
        xfer = recv_val & recv_rdy;  // settled just before the edge
        @(posedge clk);
        #10;
        busy = 1'b0;
        for (int s = 0; s < n_inputs; s++) begin
          if (xfer[s]) begin
            recv_val[s] = 1'b0;
            if (left[s] > 0) left[s]--;
          end
          if (left[s] > 0) busy = 1'b1;
        end
        cycles++;
      end
    end
    recv_val = '0;
    send_rdy = '1;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (pending != 0) begin
      if (cycles == drain_limit) fail_now("output buffers did not drain");
      else begin
        @(posedge clk);
        #10;
        cycles++;
      end
    end
  endtask

  initial begin
    rst         = 1'b1;
    recv_msg    = '0;
    recv_val    = '0;
    send_rdy    = '1;
    control     = '0;
    control_val = 1'b0;
    test_id     = 0;
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;

    // offered messages must wait until routing is loaded
    test_id = 1;
    for (int s = 0; s < n_inputs; s++) recv_msg[s*msg_w +: msg_w] = $random(seed);
    recv_val = '1;
    repeat (4) begin
      @(posedge clk);
      #10;
    end
    recv_val = '0;

    test_id = 2;
    send_control(routing(2, 0, 3, 1));
    run_traffic(20, 4'b1111, 4'b0000, 4'b0000);
    wait_drained();

    // input 1 feeds outputs 0, 1 and 3 while output 2 is off
    test_id = 3;
    send_control(routing(1, 1, -1, 1));
    run_traffic(16, 4'b0010, 4'b1101, 4'b0000);
    wait_drained();

    test_id = 4;
    run_traffic(24, 4'b0010, 4'b0000, 4'b1010);
    wait_drained();

    test_id = 5;
    fork
      run_traffic(12, 4'b1111, 4'b0000, 4'b0001);
      begin
        repeat (6) @(posedge clk);
        #10;
        send_control(routing(3, 1, 0, 2));
      end
    join
    wait_drained();

    if (pending == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Regression failed");
      $fatal(1, "messages left in the reference queues");
    end
  end

endmodule

// File: test/tb_xbar_check.sv
module tb_xbar_check
  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [n_inputs*msg_w-1:0]  recv_msg,
  input  in_mask_t                   recv_val,
  input  in_mask_t                   recv_rdy,
  input  logic [n_outputs*msg_w-1:0] send_msg,
  input  out_mask_t                  send_val,
  input  out_mask_t                  send_rdy,
  input  ctrl_word_t                 control,
  input  logic                       control_val,
  input  logic                       control_rdy,
  input  int                         test_id,
  output int unsigned                pending,
  output logic                       failed
);
  timeunit 1ns;
  timeprecision 100ps;

  msg_t        in_msg   [n_inputs];
  msg_t        out_msg  [n_outputs];
  msg_t        exp_q    [n_outputs][$];  // reference queue per output
  msg_t        exp_head [n_outputs];
  int unsigned exp_cnt  [n_outputs];
  msg_t        held_msg [n_outputs];     // send_msg of the previous cycle
  route_vec_t  cfg_q = '0;               // routing as seen on the control bus
  logic        configured = 1'b0;
  in_mask_t    taken;
  out_mask_t   out_takes;
  logic        failed_q = 1'b0;
  event        check_failed;

  function automatic string test_name(input int id);
    case (id)
      1: return "reset_idle";
      2: return "permutation";
      3: return "fanout";
      4: return "backpressure";
      5: return "reconfig";
      default: return "startup";
    endcase
  endfunction

  for (genvar s = 0; s < n_inputs; s++) begin : g_in_view
    assign in_msg[s] = recv_msg[s*msg_w +: msg_w];
  end

  for (genvar o = 0; o < n_outputs; o++) begin : g_out_view
    assign out_msg[o] = send_msg[o*msg_w +: msg_w];
  end

  always_comb begin
    for (int s = 0; s < n_inputs; s++) begin
      taken[s] = 1'b0;
      for (int o = 0; o < n_outputs; o++) begin
        if (cfg_q[o].en && cfg_q[o].sel == port_sel_t'(s)) taken[s] = 1'b1;
      end
    end
    for (int o = 0; o < n_outputs; o++) begin
      out_takes[o] = cfg_q[o].en && recv_val[cfg_q[o].sel] && recv_rdy[cfg_q[o].sel];
    end
  end

  // scoreboard pops before it pushes within one edge
  always @(posedge clk) begin
    if (rst) begin
      for (int o = 0; o < n_outputs; o++) exp_q[o].delete();
      cfg_q      = '0;
      configured = 1'b0;
    end else begin
      for (int o = 0; o < n_outputs; o++) begin
        if (send_val[o] && send_rdy[o] && exp_q[o].size() != 0) void'(exp_q[o].pop_front());
      end
      for (int s = 0; s < n_inputs; s++) begin
        if (recv_val[s] && recv_rdy[s]) begin
          for (int o = 0; o < n_outputs; o++) begin
            if (cfg_q[o].en && cfg_q[o].sel == port_sel_t'(s)) exp_q[o].push_back(in_msg[s]);
          end
        end
      end
      if (control_val && control_rdy) begin
        cfg_q      = route_vec_t'(control);  // governs from the next edge
        configured = 1'b1;
      end
    end
    pending = 0;
    for (int o = 0; o < n_outputs; o++) begin
      exp_cnt[o]  = exp_q[o].size();
      exp_head[o] = (exp_q[o].size() != 0) ? exp_q[o][0] : '0;
      held_msg[o] = out_msg[o];
      pending     = pending + exp_q[o].size();
    end
  end

  always @(check_failed) failed_q = 1'b1;
  assign failed = failed_q;

  a_reset_quiet: assert property (@(posedge clk) disable iff (rst)
    !configured |-> {send_val, recv_rdy, control_rdy} == 9'h001)
    else begin
      $display("Error: %s idle ports expected %h actual %h", test_name(test_id), 9'h001,
               $sampled({send_val, recv_rdy, control_rdy}));
      -> check_failed;
    end

  for (genvar s = 0; s < n_inputs; s++) begin : g_in_chk
    a_unrouted_wait: assert property (@(posedge clk) disable iff (rst)
      recv_rdy[s] |-> taken[s])
      else begin
        $display("input %0d was offered ready with no output routed to it", s);
        -> check_failed;
      end
  end

  for (genvar o = 0; o < n_outputs; o++) begin : g_out_chk
    a_next_cycle: assert property (@(posedge clk) disable iff (rst)
      out_takes[o] |=> send_val[o])
      else begin
        $display("output %0d did not show an accepted message on the next cycle", o);
        -> check_failed;
      end

    a_send_known: assert property (@(posedge clk) disable iff (rst)
      send_val[o] && send_rdy[o] |-> exp_cnt[o] != 0)
      else begin
        $display("output %0d sent a message that no accepted input produced", o);
        -> check_failed;
      end

    a_send_value: assert property (@(posedge clk) disable iff (rst)
      send_val[o] && send_rdy[o] && exp_cnt[o] != 0 |-> out_msg[o] == exp_head[o])
      else begin
        $display("Error: %s output %0d expected %h actual %h", test_name(test_id), o,
                 $sampled(exp_head[o]), $sampled(out_msg[o]));
        -> check_failed;
      end

    a_hold: assert property (@(posedge clk) disable iff (rst)
      send_val[o] && !send_rdy[o] |=> send_val[o] && out_msg[o] == held_msg[o])
      else begin
        $display("Error: %s stalled output %0d expected %h actual %h", test_name(test_id), o,
                 $sampled(held_msg[o]), $sampled(out_msg[o]));
        -> check_failed;
      end
  end

endmodule

// File: verilog/xbar_top.sv
module xbar_top
  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;
(
  input  logic [n_inputs*msg_w-1:0]  recv_msg,
  input  in_mask_t                   recv_val,
  output in_mask_t                   recv_rdy,

  output logic [n_outputs*msg_w-1:0] send_msg,
  output out_mask_t                  send_val,
  input  out_mask_t                  send_rdy,

  input  logic                       rst,
  input  logic                       clk,

  input  ctrl_word_t                 control,
  input  logic                       control_val,
  output logic                       control_rdy
);

  msg_t       in_msg  [n_inputs];   // per-input view of recv_msg
  msg_t       out_msg [n_outputs];  // per-output view of send_msg
  msg_t       buf_msg [n_outputs];
  out_mask_t  buf_val;
  out_mask_t  buf_rdy;
  route_vec_t route;

  for (genvar i = 0; i < n_inputs; i++) begin : g_in
    assign in_msg[i] = recv_msg[i*msg_w +: msg_w];
  end

  for (genvar o = 0; o < n_outputs; o++) begin : g_out_msg
    assign send_msg[o*msg_w +: msg_w] = out_msg[o];
  end

  xbar_ctrl_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .control     (control),
    .control_val (control_val),
    .control_rdy (control_rdy),
    .route       (route)
  );

  xbar_route u_route (
    .clk      (clk),
    .route    (route),
    .recv_msg (in_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .buf_msg  (buf_msg),
    .buf_val  (buf_val),
    .buf_rdy  (buf_rdy)
  );

  // one registered slot per output
  for (genvar o = 0; o < n_outputs; o++) begin : g_out
    xbar_send_buf u_send_buf (
      .clk      (clk),
      .rst      (rst),
      .in_val   (buf_val[o]),
      .in_msg   (buf_msg[o]),
      .in_rdy   (buf_rdy[o]),
      .send_val (send_val[o]),
      .send_msg (out_msg[o]),
      .send_rdy (send_rdy[o])
    );
  end

endmodule

// File: verilog/xbar_send_buf.sv
module xbar_send_buf
  import xbar_msg_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic in_val,
  input  msg_t in_msg,
  output logic in_rdy,
  output logic send_val,
  output msg_t send_msg,
  input  logic send_rdy
);

  slot_t slot;
  logic  load;
  logic  drain;

  assign send_val = slot.full;
  assign send_msg = slot.msg;

  assign drain  = send_val && send_rdy;
  assign in_rdy = !slot.full || send_rdy;  // empty, or emptying this cycle
  assign load   = in_val && in_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      slot.full <= 1'b0;
    end else if (load) begin
      slot.full <= 1'b1;
    end else if (drain) begin
      slot.full <= 1'b0;
    end

    if (load) begin
      slot.msg <= in_msg;
    end
  end

  // stalled output keeps its message until it is taken
  a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
    send_val && !send_rdy |=> send_val && $stable(send_msg));

endmodule

// File: verilog/xbar_route.sv
module xbar_route
  import xbar_cfg_pkg::*;
  import xbar_msg_pkg::*;
(
  input  logic       clk,
  input  route_vec_t route,
  input  msg_t       recv_msg [n_inputs],
  input  in_mask_t   recv_val,
  output in_mask_t   recv_rdy,
  output msg_t       buf_msg [n_outputs],
  output out_mask_t  buf_val,
  input  out_mask_t  buf_rdy
);

  out_mask_t takers [n_inputs];  // enabled outputs that select each input
  in_mask_t  in_go;

  // looks up the routing table for the checks below
  function automatic logic has_taker(route_vec_t r, int unsigned s);
    logic hit;
    hit = 1'b0;
    for (int o = 0; o < n_outputs; o++) begin
      if (r[o].en && r[o].sel == port_sel_t'(s)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  always_comb begin
    for (int s = 0; s < n_inputs; s++) begin
      for (int o = 0; o < n_outputs; o++) begin
        takers[s][o] = route[o].en && (route[o].sel == port_sel_t'(s));
      end
      // input moves only when every taker can load it
      in_go[s] = (takers[s] != '0) && ((takers[s] & ~buf_rdy) == '0);
    end
  end

  assign recv_rdy = in_go;

  for (genvar o = 0; o < n_outputs; o++) begin : g_out
    port_sel_t src;
    out_mask_t others;

    assign src    = route[o].sel;
    assign others = takers[src] & ~(out_mask_t'(1) << o);  // own ready left out

    assign buf_val[o] = route[o].en && recv_val[src] && ((others & ~buf_rdy) == '0);
    assign buf_msg[o] = recv_msg[src];

    // a buffer load always consumes its source input
    a_load_takes_src: assert property (@(posedge clk)
      buf_val[o] && buf_rdy[o] |-> recv_val[src] && recv_rdy[src]);
  end

  for (genvar s = 0; s < n_inputs; s++) begin : g_in
    // an accepted input reaches every output that selects it
    a_fanout_whole: assert property (@(posedge clk)
      recv_val[s] && recv_rdy[s] |-> (takers[s] & ~(buf_val & buf_rdy)) == '0);

    // unrouted inputs are never offered ready
    a_rdy_needs_taker: assert property (@(posedge clk)
      recv_rdy[s] |-> has_taker(route, s));
  end

endmodule

// File: verilog/xbar_ctrl_decode.sv
module xbar_ctrl_decode
  import xbar_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ctrl_word_t control,
  input  logic       control_val,
  output logic       control_rdy,
  output route_vec_t route
);

  dec_state_t state;
  route_vec_t route_q;
  logic       ctrl_xfer;

  // a new word simply replaces the active routing, so the port never stalls
  assign control_rdy = 1'b1;
  assign ctrl_xfer   = control_val && control_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= dec_unconfigured;
      route_q <= '0;                         // every output disabled
    end else begin
      case (state)
        dec_unconfigured: begin
          if (ctrl_xfer) begin
            route_q <= route_vec_t'(control);
            state   <= dec_active;
          end
        end
        dec_active: begin
          if (ctrl_xfer) route_q <= route_vec_t'(control);  // reconfigure
        end
        default: state <= dec_unconfigured;
      endcase
    end
  end

  assign route = route_q;  // new word governs from the next cycle

  // no output may be enabled until a control word has been taken
  a_unconfigured_idle: assert property (@(posedge clk) disable iff (rst)
    state == dec_unconfigured |-> route_q == '0);

endmodule

// File: verilog/xbar_msg_pkg.sv
package xbar_msg_pkg;

  import xbar_cfg_pkg::*;

  localparam int msg_w = 32;

  // one message
  typedef logic [msg_w-1:0] msg_t;

  // one bit per port
  typedef logic [n_inputs-1:0]  in_mask_t;
  typedef logic [n_outputs-1:0] out_mask_t;

  // output buffer entry
  typedef struct packed {
    logic full;
    msg_t msg;
  } slot_t;

endpackage

// File: verilog/xbar_cfg_pkg.sv
package xbar_cfg_pkg;

  // port counts
  localparam int n_inputs  = 4;
  localparam int n_outputs = 4;

  localparam int sel_w = $clog2(n_inputs);  // 2 bits for 4 inputs

  // names one input port
  typedef logic [sel_w-1:0] port_sel_t;

  // routing of a single output
  typedef struct packed {
    logic      en;   // output takes messages
    port_sel_t sel;  // input it takes them from
  } route_cfg_t;

  // full routing table with output 0 in the low bits
  typedef route_cfg_t [n_outputs-1:0] route_vec_t;

  // control word is the routing table as raw bits
  localparam int ctrl_w = $bits(route_vec_t);

  typedef logic [ctrl_w-1:0] ctrl_word_t;

  // decoder FSM
  typedef enum logic {
    dec_unconfigured,  // no control word seen since reset
    dec_active         // routing loaded
  } dec_state_t;

endpackage
